// ==== hw/vdec_isa_pkg.sv ====
//********************
// vector instruction encodings: opcode, funct3, funct6 and the
// two views of an instruction word, shared by the group decoders
//********************
`default_nettype none

package vdec_isa_pkg;

  // only the vector major opcode is decoded
  typedef enum logic [6:0] {
    VECTOR = 7'b1010111
  } opcode_t;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // integer group funct6
  typedef enum logic [5:0] {
    VADD       = 6'b000000, VSUB   = 6'b000010, VRSUB  = 6'b000011,
    VMINU      = 6'b000100, VMIN   = 6'b000101, VMAXU  = 6'b000110,
    VMAX       = 6'b000111, VAND   = 6'b001001, VOR    = 6'b001010,
    VXOR       = 6'b001011, VRGATHER = 6'b001100, VSLIDEUP = 6'b001110,
    VSLIDEDOWN = 6'b001111, VMSEQ  = 6'b011000, VMSNE  = 6'b011001,
    VMSLTU     = 6'b011010, VMSLT  = 6'b011011, VMSLEU = 6'b011100,
    VMSLE      = 6'b011101, VMSGTU = 6'b011110, VMSGT  = 6'b011111,
    VSLL       = 6'b100101, VSRL   = 6'b101000, VSRA   = 6'b101001
  } vopi_t;

  // mask/multiply group funct6
  typedef enum logic [5:0] {
    VREDSUM   = 6'b000000, VREDAND   = 6'b000001, VREDOR      = 6'b000010,
    VREDXOR   = 6'b000011, VREDMINU  = 6'b000100, VREDMIN     = 6'b000101,
    VREDMAXU  = 6'b000110, VREDMAX   = 6'b000111, VSLIDE1UP   = 6'b001110,
    VSLIDE1DOWN = 6'b001111, VDIVU   = 6'b100000, VDIV        = 6'b100001,
    VREMU     = 6'b100010, VREM      = 6'b100011, VMULHU      = 6'b100100,
    VMUL      = 6'b100101, VMULHSU   = 6'b100110, VMULH       = 6'b100111
  } vopm_t;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    vfunct3_t   funct3;
    logic [4:0] vd;
    opcode_t    opcode;
  } varith_t;

  // vsetvli immediate also reaches into sel[0]
  typedef struct packed {
    logic [1:0] sel;
    logic [9:0] zimm;
    logic [4:0] rs1;
    vfunct3_t   funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } vcfg_t;

  typedef union packed {
    varith_t arith;
    vcfg_t   cfg;
  } vinstr_u;

endpackage

`default_nettype wire

// ==== hw/vdec_ctrl_pkg.sv ====
//********************
// decoded control types: operation, functional unit, ALU op,
// operand source and configuration kind
//********************
`default_nettype none

package vdec_ctrl_pkg;

  localparam int unsigned NUM_UNITS = 5;

  typedef enum logic [5:0] {
    BAD_OP,
    // integer group
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VSLIDEUP, OP_VSLIDEDOWN, OP_VRGATHER,
    // mask/multiply group
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VSLIDE1UP, OP_VSLIDE1DOWN
  } vop_t;

  // value doubles as bit index into the unit enable mask
  typedef enum logic [2:0] {
    ARITH = 3'd0,
    RED   = 3'd1,
    MUL   = 3'd2,
    DIV   = 3'd3,
    PERM  = 3'd4
  } fu_t;

  typedef enum logic [3:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR,
    VALU_SLL, VALU_SRL, VALU_SRA, VALU_COMP, VALU_MM, VALU_MOVE
  } valu_op_t;

  typedef enum logic [1:0] {
    V = 2'd0,
    X = 2'd1,
    I = 2'd2
  } rs1_kind_t;

  typedef enum logic [1:0] {
    NOT_CFG  = 2'd0,
    VSETVLI  = 2'd1,
    VSETIVLI = 2'd2,
    VSETVL   = 2'd3
  } cfgsel_t;

endpackage

`default_nettype wire

// ==== hw/vdec_op_if.sv ====
//********************
// one group decoder's verdict, read by the control generator
//********************
`timescale 1ns/1ps
`default_nettype none

interface vdec_op_if
  import vdec_ctrl_pkg::*;
();

  vop_t op;
  logic legal;
  logic in_group;
  logic scalar_rs1;
  logic imm;

  modport dec (output op, legal, in_group, scalar_rs1, imm);
  modport gen (input op, legal, in_group, scalar_rs1, imm);

endinterface

`default_nettype wire

// ==== hw/vdec_opi_decode.sv ====
//********************
// integer group decode: funct6 and funct3 to an operation
// combinational, verdict only meaningful when in_group is set
//********************
`timescale 1ns/1ps
`default_nettype none

module vdec_opi_decode
  import vdec_isa_pkg::*, vdec_ctrl_pkg::*;
(
  input  vinstr_u   instr,
  vdec_op_if.dec    op_out
);

  vopi_t funct6;
  vop_t  op;
  logic  vv, vx, vi;

  assign funct6 = vopi_t'(instr.arith.funct6);
  assign vv     = (instr.arith.funct3 == OPIVV);
  assign vx     = (instr.arith.funct3 == OPIVX);
  assign vi     = (instr.arith.funct3 == OPIVI);

  always_comb begin
    op = BAD_OP;
    case (funct6)
      VADD:       op = (vv || vx || vi) ? OP_VADD : BAD_OP;
      VSUB:       op = (vv || vx) ? OP_VSUB : BAD_OP;
      VRSUB:      op = (vx || vi) ? OP_VRSUB : BAD_OP;
      VMINU:      op = (vv || vx) ? OP_VMINU : BAD_OP;
      VMIN:       op = (vv || vx) ? OP_VMIN : BAD_OP;
      VMAXU:      op = (vv || vx) ? OP_VMAXU : BAD_OP;
      VMAX:       op = (vv || vx) ? OP_VMAX : BAD_OP;
      VAND:       op = (vv || vx || vi) ? OP_VAND : BAD_OP;
      VOR:        op = (vv || vx || vi) ? OP_VOR : BAD_OP;
      VXOR:       op = (vv || vx || vi) ? OP_VXOR : BAD_OP;
      VRGATHER:   op = (vv || vx || vi) ? OP_VRGATHER : BAD_OP;
      // vector-vector slideup form is a gather
      VSLIDEUP:   op = (vx || vi) ? OP_VSLIDEUP : (vv ? OP_VRGATHER : BAD_OP);
      VSLIDEDOWN: op = (vx || vi) ? OP_VSLIDEDOWN : BAD_OP;
      VMSEQ:      op = (vv || vx || vi) ? OP_VMSEQ : BAD_OP;
      VMSNE:      op = (vv || vx || vi) ? OP_VMSNE : BAD_OP;
      VMSLTU:     op = (vv || vx) ? OP_VMSLTU : BAD_OP;
      VMSLT:      op = (vv || vx) ? OP_VMSLT : BAD_OP;
      VMSLEU:     op = (vv || vx || vi) ? OP_VMSLEU : BAD_OP;
      VMSLE:      op = (vv || vx || vi) ? OP_VMSLE : BAD_OP;
      VMSGTU:     op = (vx || vi) ? OP_VMSGTU : BAD_OP;
      VMSGT:      op = (vx || vi) ? OP_VMSGT : BAD_OP;
      VSLL:       op = (vv || vx || vi) ? OP_VSLL : BAD_OP;
      VSRL:       op = (vv || vx || vi) ? OP_VSRL : BAD_OP;
      VSRA:       op = (vv || vx || vi) ? OP_VSRA : BAD_OP;
      default:    op = BAD_OP;
    endcase
  end

  assign op_out.op         = op;
  assign op_out.legal      = (op != BAD_OP);
  assign op_out.in_group   = (instr.arith.opcode == VECTOR) && (vv || vx || vi);
  assign op_out.scalar_rs1 = op_out.in_group && vx;
  assign op_out.imm        = op_out.in_group && vi;

endmodule

`default_nettype wire

// ==== hw/vdec_opm_decode.sv ====
//********************
// reduction, multiply/divide and slide1 group decode
// combinational, verdict only meaningful when in_group is set
//********************
`timescale 1ns/1ps
`default_nettype none

module vdec_opm_decode
  import vdec_isa_pkg::*, vdec_ctrl_pkg::*;
(
  input  vinstr_u   instr,
  vdec_op_if.dec    op_out
);

  vopm_t funct6;
  vop_t  op;
  logic  vv, vx;

  assign funct6 = vopm_t'(instr.arith.funct6);
  assign vv     = (instr.arith.funct3 == OPMVV);
  assign vx     = (instr.arith.funct3 == OPMVX);

  always_comb begin
    op = BAD_OP;
    case (funct6)
      // reductions are vector-vector only
      VREDSUM:     op = vv ? OP_VREDSUM : BAD_OP;
      VREDAND:     op = vv ? OP_VREDAND : BAD_OP;
      VREDOR:      op = vv ? OP_VREDOR : BAD_OP;
      VREDXOR:     op = vv ? OP_VREDXOR : BAD_OP;
      VREDMINU:    op = vv ? OP_VREDMINU : BAD_OP;
      VREDMIN:     op = vv ? OP_VREDMIN : BAD_OP;
      VREDMAXU:    op = vv ? OP_VREDMAXU : BAD_OP;
      VREDMAX:     op = vv ? OP_VREDMAX : BAD_OP;
      VMUL:        op = (vv || vx) ? OP_VMUL : BAD_OP;
      VMULH:       op = (vv || vx) ? OP_VMULH : BAD_OP;
      VMULHU:      op = (vv || vx) ? OP_VMULHU : BAD_OP;
      VMULHSU:     op = (vv || vx) ? OP_VMULHSU : BAD_OP;
      VDIVU:       op = (vv || vx) ? OP_VDIVU : BAD_OP;
      VDIV:        op = (vv || vx) ? OP_VDIV : BAD_OP;
      VREMU:       op = (vv || vx) ? OP_VREMU : BAD_OP;
      VREM:        op = (vv || vx) ? OP_VREM : BAD_OP;
      VSLIDE1UP:   op = vx ? OP_VSLIDE1UP : BAD_OP;
      VSLIDE1DOWN: op = vx ? OP_VSLIDE1DOWN : BAD_OP;
      default:     op = BAD_OP;
    endcase
  end

  assign op_out.op         = op;
  assign op_out.legal      = (op != BAD_OP);
  assign op_out.in_group   = (instr.arith.opcode == VECTOR) && (vv || vx);
  assign op_out.scalar_rs1 = op_out.in_group && vx;
  // no immediate forms in this group
  assign op_out.imm        = 1'b0;

endmodule

`default_nettype wire

// ==== hw/vdec_unit_cfg.sv ====
//********************
// functional unit enable mask, one bit per unit
// written by strobe, read back on cfg_rdata
//********************
`timescale 1ns/1ps
`default_nettype none

module vdec_unit_cfg
  import vdec_ctrl_pkg::*;
#(
  parameter logic [NUM_UNITS-1:0] RESET_UNIT_EN = '1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cfg_we,
  input  logic [NUM_UNITS-1:0] cfg_wdata,
  output logic [NUM_UNITS-1:0] unit_en,
  output logic [NUM_UNITS-1:0] cfg_rdata
);

  // new mask seen by instructions sampled from the next edge on
  always_ff @(posedge clk) begin
    if (rst) begin
      unit_en <= RESET_UNIT_EN;
    end else if (cfg_we) begin
      unit_en <= cfg_wdata;
    end
  end

  assign cfg_rdata = unit_en;

endmodule

`default_nettype wire

// ==== hw/vdec_ctrl_gen.sv ====
//********************
// merges the group verdicts, derives unit, ALU op and operand
// kind, and registers the control word on instr_valid
//********************
`timescale 1ns/1ps
`default_nettype none

module vdec_ctrl_gen
  import vdec_isa_pkg::*, vdec_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instr_valid,
  input  vinstr_u              instr,
  vdec_op_if.gen               opi,
  vdec_op_if.gen               opm,
  input  logic [NUM_UNITS-1:0] unit_en,
  output logic                 out_valid,
  output logic                 illegal_insn,
  output fu_t                  fu_type,
  output valu_op_t             aluop,
  output logic                 is_signed,
  output rs1_kind_t            rs1_type,
  output cfgsel_t              cfgsel,
  output logic [4:0]           vd,
  output logic [4:0]           vs1,
  output logic [4:0]           vs2,
  output logic                 vm
);

  vop_t      op;
  logic      in_grp, grp_legal, is_cfg, signed_d, illegal_d;
  fu_t       fu_d;
  valu_op_t  alu_d;
  rs1_kind_t rs1_d;
  cfgsel_t   cfg_d;

  assign op        = opi.in_group ? opi.op : (opm.in_group ? opm.op : BAD_OP);
  assign in_grp    = opi.in_group || opm.in_group;
  assign grp_legal = opi.in_group ? opi.legal : opm.legal;
  assign is_cfg    = (instr.cfg.opcode == VECTOR) && (instr.cfg.funct3 == OPCFG);

  // top bit clear means vsetvli, else bit 30 picks vsetivli
  always_comb begin
    cfg_d = NOT_CFG;
    if (is_cfg) begin
      if (!instr.cfg.sel[1]) cfg_d = VSETVLI;
      else if (instr.cfg.sel[0]) cfg_d = VSETIVLI;
      else cfg_d = VSETVL;
    end
  end

  always_comb begin
    case (op)
      OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX:         fu_d = RED;
      OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU:                 fu_d = MUL;
      OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:                     fu_d = DIV;
      OP_VSLIDEUP, OP_VSLIDEDOWN, OP_VRGATHER,
      OP_VSLIDE1UP, OP_VSLIDE1DOWN:                             fu_d = PERM;
      default:                                                  fu_d = ARITH;
    endcase
  end

  always_comb begin
    case (op)
      OP_VADD, OP_VREDSUM:               alu_d = VALU_ADD;
      OP_VSUB, OP_VRSUB:                 alu_d = VALU_SUB;
      OP_VAND, OP_VREDAND:               alu_d = VALU_AND;
      OP_VOR, OP_VREDOR:                 alu_d = VALU_OR;
      OP_VXOR, OP_VREDXOR:               alu_d = VALU_XOR;
      OP_VSRL:                           alu_d = VALU_SRL;
      OP_VSRA:                           alu_d = VALU_SRA;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: alu_d = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: alu_d = VALU_MM;
      // shift left, and don't-care for non-ALU units
      default:                           alu_d = VALU_SLL;
    endcase
  end

  always_comb begin
    case (op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ, OP_VMSNE,
      OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM, OP_VREDMIN, OP_VREDMAX,
      OP_VDIV, OP_VREM, OP_VMUL, OP_VMULHSU, OP_VMULH: signed_d = 1'b1;
      default:                                         signed_d = 1'b0;
    endcase
  end

  always_comb begin
    if (opi.scalar_rs1 || opm.scalar_rs1 || (cfg_d == VSETVLI) || (cfg_d == VSETVL)) begin
      rs1_d = X;
    end else if (opi.imm || opm.imm || (cfg_d == VSETIVLI)) begin
      rs1_d = I;
    end else begin
      rs1_d = V;
    end
  end

  // config instructions are never illegal
  assign illegal_d = !is_cfg && (!in_grp || !grp_legal || !unit_en[fu_d]);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid    <= 1'b0;
      illegal_insn <= 1'b0;
      fu_type      <= ARITH;
      aluop        <= VALU_ADD;
      is_signed    <= 1'b0;
      rs1_type     <= V;
      cfgsel       <= NOT_CFG;
      vd           <= '0;
      vs1          <= '0;
      vs2          <= '0;
      vm           <= 1'b0;
    end else begin
      out_valid <= instr_valid;
      if (instr_valid) begin
        illegal_insn <= illegal_d;
        fu_type      <= fu_d;
        aluop        <= alu_d;
        is_signed    <= signed_d;
        rs1_type     <= rs1_d;
        cfgsel       <= cfg_d;
        vd           <= instr.arith.vd;
        vs1          <= instr.arith.vs1;
        vs2          <= instr.arith.vs2;
        vm           <= instr.arith.vm;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/vec_decode_top.sv ====
//********************
// vector decoder top: group decoders, unit enable register and
// control generator, one cycle from instr_valid to out_valid
//********************
`timescale 1ns/1ps
`default_nettype none

module vec_decode_top
  import vdec_ctrl_pkg::*;
#(
  parameter logic [NUM_UNITS-1:0] RESET_UNIT_EN = '1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instr_valid,
  input  logic [31:0]          instr,
  input  logic                 cfg_we,
  input  logic [NUM_UNITS-1:0] cfg_wdata,
  output logic [NUM_UNITS-1:0] cfg_rdata,
  output logic                 out_valid,
  output logic                 illegal_insn,
  output fu_t                  fu_type,
  output valu_op_t             aluop,
  output logic                 is_signed,
  output rs1_kind_t            rs1_type,
  output cfgsel_t              cfgsel,
  output logic [4:0]           vd,
  output logic [4:0]           vs1,
  output logic [4:0]           vs2,
  output logic                 vm
);

  logic [NUM_UNITS-1:0] unit_en;

  vdec_op_if opi_if ();
  vdec_op_if opm_if ();

  vdec_opi_decode u_opi_decode (
    .instr  (instr),
    .op_out (opi_if.dec)
  );

  vdec_opm_decode u_opm_decode (
    .instr  (instr),
    .op_out (opm_if.dec)
  );

  vdec_unit_cfg #(
    .RESET_UNIT_EN (RESET_UNIT_EN)
  ) u_unit_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_wdata (cfg_wdata),
    .unit_en   (unit_en),
    .cfg_rdata (cfg_rdata)
  );

  vdec_ctrl_gen u_ctrl_gen (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .opi          (opi_if.gen),
    .opm          (opm_if.gen),
    .unit_en      (unit_en),
    .out_valid    (out_valid),
    .illegal_insn (illegal_insn),
    .fu_type      (fu_type),
    .aluop        (aluop),
    .is_signed    (is_signed),
    .rs1_type     (rs1_type),
    .cfgsel       (cfgsel),
    .vd           (vd),
    .vs1          (vs1),
    .vs2          (vs2),
    .vm           (vm)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
//********************
// testbench clock and reset source
// reset released shortly after the last reset edge
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== dv/tb_vec_decode_assert.sv ====
//********************
// timing and reset assertions for the decoder top,
// attached to vec_decode_top by bind from the testbench
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_vec_decode_assert
  import vdec_ctrl_pkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic                 instr_valid,
  input logic                 out_valid,
  input logic                 illegal_insn,
  input logic [NUM_UNITS-1:0] cfg_rdata
);

  // read by the testbench at the end of the run
  int unsigned fail_count = 0;

  a_reset_state: assert property (@(posedge clk)
    rst |=> (!out_valid && !illegal_insn && cfg_rdata == '1))
    else begin
      $error("outputs or enable register not at reset values after reset");
      fail_count++;
    end

  a_valid_follows: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> out_valid)
    else begin
      $error("out_valid missing one cycle after instr_valid");
      fail_count++;
    end

  a_valid_drops: assert property (@(posedge clk) disable iff (rst)
    !instr_valid |=> !out_valid)
    else begin
      $error("out_valid high without an instruction the cycle before");
      fail_count++;
    end

  // back-to-back input gives two outputs in a row
  a_back_to_back: assert property (@(posedge clk) disable iff (rst)
    instr_valid ##1 instr_valid |=> (out_valid && $past(out_valid)))
    else begin
      $error("back-to-back instructions did not give one out_valid each");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/tb_vec_decode.sv ====
//********************
// testbench for the vector decoder: table sweeps, unit disable
// and random words, checked by assertions against a reference
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_vec_decode
  import vdec_ctrl_pkg::*;
();

  localparam int         N_RANDOM    = 400;
  localparam int         N_TESTS     = 6 * 512 + N_RANDOM;
  localparam int         ID_SWEEP    = 0;
  localparam int         ID_CFG      = 1;
  localparam int         ID_UNIT_OFF = 2;
  localparam int         ID_RANDOM   = 3;
  localparam logic [6:0] OPC_VECTOR  = 7'b1010111;

  typedef struct packed {
    logic        illegal;
    logic        chk_fu;
    logic        chk_alu;
    fu_t         fu;
    valu_op_t    alu;
    logic        sgn;
    rs1_kind_t   rs1;
    cfgsel_t     cfg;
    logic [15:0] regs;
  } exp_t;

  logic                 clk;
  logic                 rst;
  logic                 instr_valid;
  logic [31:0]          instr;
  logic                 cfg_we;
  logic [NUM_UNITS-1:0] cfg_wdata;
  logic [NUM_UNITS-1:0] cfg_rdata;
  logic                 out_valid;
  logic                 illegal_insn;
  fu_t                  fu_type;
  valu_op_t             aluop;
  logic                 is_signed;
  rs1_kind_t            rs1_type;
  cfgsel_t              cfgsel;
  logic [4:0]           vd;
  logic [4:0]           vs1;
  logic [4:0]           vs2;
  logic                 vm;
  logic [NUM_UNITS-1:0] en_model;
  logic [NUM_UNITS-1:0] wdata_q;
  logic [31:0]          lfsr;
  int                   test_id;
  int                   id_q;
  int                   n_tests;
  int                   errors;
  exp_t                 exp_now;
  exp_t                 exp_q;

  tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clk_gen (.clk(clk), .rst(rst));

  vec_decode_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .cfg_we       (cfg_we),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .out_valid    (out_valid),
    .illegal_insn (illegal_insn),
    .fu_type      (fu_type),
    .aluop        (aluop),
    .is_signed    (is_signed),
    .rs1_type     (rs1_type),
    .cfgsel       (cfgsel),
    .vd           (vd),
    .vs1          (vs1),
    .vs2          (vs2),
    .vm           (vm)
  );

  bind vec_decode_top tb_vec_decode_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .out_valid    (out_valid),
    .illegal_insn (illegal_insn),
    .cfg_rdata    (cfg_rdata)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // row is {vv vx vi forms, unit, alu op, signed}
  function automatic logic [10:0] table_row(input logic opm, input logic [5:0] f6);
    case ({opm, f6})
      7'b0_000000: return {3'b111, ARITH, VALU_ADD, 1'b1};
      7'b0_000010: return {3'b110, ARITH, VALU_SUB, 1'b1};
      7'b0_000011: return {3'b011, ARITH, VALU_SUB, 1'b1};
      7'b0_000100: return {3'b110, ARITH, VALU_MM, 1'b0};
      7'b0_000101: return {3'b110, ARITH, VALU_MM, 1'b1};
      7'b0_000110: return {3'b110, ARITH, VALU_MM, 1'b0};
      7'b0_000111: return {3'b110, ARITH, VALU_MM, 1'b1};
      7'b0_001001: return {3'b111, ARITH, VALU_AND, 1'b0};
      7'b0_001010: return {3'b111, ARITH, VALU_OR, 1'b0};
      7'b0_001011: return {3'b111, ARITH, VALU_XOR, 1'b0};
      7'b0_001100: return {3'b111, PERM, VALU_MOVE, 1'b0};
      // vv slideup decodes as gather, same unit
      7'b0_001110: return {3'b111, PERM, VALU_MOVE, 1'b0};
      7'b0_001111: return {3'b011, PERM, VALU_MOVE, 1'b0};
      7'b0_011000: return {3'b111, ARITH, VALU_COMP, 1'b1};
      7'b0_011001: return {3'b111, ARITH, VALU_COMP, 1'b1};
      7'b0_011010: return {3'b110, ARITH, VALU_COMP, 1'b0};
      7'b0_011011: return {3'b110, ARITH, VALU_COMP, 1'b1};
      7'b0_011100: return {3'b111, ARITH, VALU_COMP, 1'b0};
      7'b0_011101: return {3'b111, ARITH, VALU_COMP, 1'b1};
      7'b0_011110: return {3'b011, ARITH, VALU_COMP, 1'b0};
      7'b0_011111: return {3'b011, ARITH, VALU_COMP, 1'b1};
      7'b0_100101: return {3'b111, ARITH, VALU_SLL, 1'b0};
      7'b0_101000: return {3'b111, ARITH, VALU_SRL, 1'b0};
      7'b0_101001: return {3'b111, ARITH, VALU_SRA, 1'b0};
      7'b1_000000: return {3'b100, RED, VALU_ADD, 1'b1};
      7'b1_000001: return {3'b100, RED, VALU_AND, 1'b0};
      7'b1_000010: return {3'b100, RED, VALU_OR, 1'b0};
      7'b1_000011: return {3'b100, RED, VALU_XOR, 1'b0};
      7'b1_000100: return {3'b100, RED, VALU_MM, 1'b0};
      7'b1_000101: return {3'b100, RED, VALU_MM, 1'b1};
      7'b1_000110: return {3'b100, RED, VALU_MM, 1'b0};
      7'b1_000111: return {3'b100, RED, VALU_MM, 1'b1};
      7'b1_001110: return {3'b010, PERM, VALU_MOVE, 1'b0};
      7'b1_001111: return {3'b010, PERM, VALU_MOVE, 1'b0};
      7'b1_100000: return {3'b110, DIV, VALU_MOVE, 1'b0};
      7'b1_100001: return {3'b110, DIV, VALU_MOVE, 1'b1};
      7'b1_100010: return {3'b110, DIV, VALU_MOVE, 1'b0};
      7'b1_100011: return {3'b110, DIV, VALU_MOVE, 1'b1};
      7'b1_100100: return {3'b110, MUL, VALU_MOVE, 1'b0};
      7'b1_100101: return {3'b110, MUL, VALU_MOVE, 1'b1};
      7'b1_100110: return {3'b110, MUL, VALU_MOVE, 1'b1};
      7'b1_100111: return {3'b110, MUL, VALU_MOVE, 1'b1};
      default:     return '0;
    endcase
  endfunction

  function automatic exp_t ref_decode(input logic [31:0] w, input logic [NUM_UNITS-1:0] en);
    exp_t        e;
    logic [2:0]  f3;
    logic        vec;
    logic        opi;
    logic        opm;
    logic        ok;
    logic [10:0] row;
    e      = '0;
    f3     = w[14:12];
    vec    = (w[6:0] == OPC_VECTOR);
    opi    = vec && (f3 == 3'b000 || f3 == 3'b011 || f3 == 3'b100);
    opm    = vec && (f3 == 3'b010 || f3 == 3'b110);
    e.regs = {w[11:7], w[19:15], w[24:20], w[25]};
    // configuration words are never illegal
    if (vec && f3 == 3'b111) begin
      e.cfg = !w[31] ? VSETVLI : (w[30] ? VSETIVLI : VSETVL);
      e.rs1 = (e.cfg == VSETIVLI) ? I : X;
      return e;
    end
    e.rs1 = ((opi && f3 == 3'b100) || (opm && f3 == 3'b110)) ? X :
            ((opi && f3 == 3'b011) ? I : V);
    row = table_row(opm, w[31:26]);
    case (f3)
      3'b000, 3'b010: ok = row[10];
      3'b100, 3'b110: ok = row[9];
      3'b011:         ok = row[8];
      default:        ok = 1'b0;
    endcase
    e.fu      = fu_t'(row[7:5]);
    e.alu     = valu_op_t'(row[4:1]);
    e.sgn     = row[0];
    e.illegal = !(opi || opm) || !ok || !en[row[7:5]];
    e.chk_fu  = !e.illegal;
    e.chk_alu = !e.illegal && (e.fu == ARITH || e.fu == RED);
    return e;
  endfunction

  function automatic string test_label(input int id);
    case (id)
      ID_SWEEP:    return "group_sweep";
      ID_CFG:      return "config";
      ID_UNIT_OFF: return "unit_disable";
      default:     return "random";
    endcase
  endfunction

  task automatic report_mismatch(input string field, input int id,
                                 input logic [15:0] e, input logic [15:0] a);
    errors++;
    $display("Fail %s %s expected %0h actual %0h", test_label(id), field, e, a);
  endtask

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic send(input logic [31:0] w, input int id);
    @(posedge clk);
    #5;
    instr       = w;
    instr_valid = 1'b1;
    test_id     = id;
    n_tests++;
  endtask

  task automatic idle();
    @(posedge clk);
    #5;
    instr_valid = 1'b0;
  endtask

  task automatic write_en(input logic [NUM_UNITS-1:0] m);
    @(posedge clk);
    #5;
    instr_valid = 1'b0;
    cfg_we      = 1'b1;
    cfg_wdata   = m;
    @(posedge clk);
    #5;
    cfg_we   = 1'b0;
    en_model = m;
  endtask

  // every funct6 against every funct3, random register fields
  task automatic run_sweep(input int id);
    logic [31:0] r;
    for (int f6 = 0; f6 < 64; f6++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        take_bits(16, r);
        send({f6[5:0], r[15], r[14:10], r[9:5], f3[2:0], r[4:0], OPC_VECTOR},
             (f3 == 7) ? ID_CFG : id);
      end
    end
  endtask

  assign exp_now = ref_decode(instr, en_model);

  always @(posedge clk) begin
    exp_q   <= exp_now;
    id_q    <= test_id;
    wdata_q <= cfg_wdata;
  end

  a_illegal: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> illegal_insn == exp_q.illegal)
    else report_mismatch("illegal_insn", $sampled(id_q), $sampled(exp_q.illegal),
                         $sampled(illegal_insn));
  a_unit: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> (!exp_q.chk_fu || fu_type == exp_q.fu))
    else report_mismatch("fu_type", $sampled(id_q), $sampled(exp_q.fu), $sampled(fu_type));
  a_alu: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> (!exp_q.chk_alu || aluop == exp_q.alu))
    else report_mismatch("aluop", $sampled(id_q), $sampled(exp_q.alu), $sampled(aluop));
  a_signed: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> (!exp_q.chk_fu || is_signed == exp_q.sgn))
    else report_mismatch("is_signed", $sampled(id_q), $sampled(exp_q.sgn),
                         $sampled(is_signed));
  a_rs1: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> rs1_type == exp_q.rs1)
    else report_mismatch("rs1_type", $sampled(id_q), $sampled(exp_q.rs1), $sampled(rs1_type));
  a_cfgsel: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> cfgsel == exp_q.cfg)
    else report_mismatch("cfgsel", $sampled(id_q), $sampled(exp_q.cfg), $sampled(cfgsel));
  // register fields and mask bit echo the word
  a_fields: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> {vd, vs1, vs2, vm} == exp_q.regs)
    else report_mismatch("vd_vs1_vs2_vm", $sampled(id_q), $sampled(exp_q.regs),
                         $sampled({vd, vs1, vs2, vm}));
  a_cfg_rdata: assert property (@(posedge clk) disable iff (rst)
    cfg_we |=> cfg_rdata == wdata_q)
    else report_mismatch("cfg_rdata", ID_UNIT_OFF, $sampled(wdata_q), $sampled(cfg_rdata));

  initial begin
    repeat (N_TESTS * 4 + 50) @(posedge clk);
    $display("watchdog timeout, the stimulus did not finish in time");
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0]          r;
    logic [31:0]          s;
    logic [NUM_UNITS-1:0] mask;
    int                   total;
    instr_valid = 1'b0;
    instr       = '0;
    cfg_we      = 1'b0;
    cfg_wdata   = '1;
    en_model    = '1;
    lfsr        = 32'h1170;
    test_id     = ID_SWEEP;
    n_tests     = 0;
    errors      = 0;
    @(negedge rst);
    run_sweep(ID_SWEEP);
    // one unit switched off at a time
    for (int u = 0; u < NUM_UNITS; u++) begin
      mask    = '1;
      mask[u] = 1'b0;
      write_en(mask);
      run_sweep(ID_UNIT_OFF);
    end
    write_en('1);
    for (int n = 0; n < N_RANDOM; n++) begin
      take_bits(32, r);
      take_bits(3, s);
      // three in four keep the vector opcode
      if (s[1:0] != 2'b00) r[6:0] = OPC_VECTOR;
      if (s[2]) idle();
      send(r, ID_RANDOM);
    end
    idle();
    repeat (3) @(posedge clk);
    total = errors + u_dut.u_assert.fail_count;
    $display("run finished: %0d instructions, %0d value errors, %0d timing errors",
             n_tests, errors, u_dut.u_assert.fail_count);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/vdec_isa_pkg.sv
hw/vdec_ctrl_pkg.sv
hw/vdec_op_if.sv
hw/vdec_opi_decode.sv
hw/vdec_opm_decode.sv
hw/vdec_unit_cfg.sv
hw/vdec_ctrl_gen.sv
hw/vec_decode_top.sv
dv/tb_clk_gen.sv
dv/tb_vec_decode_assert.sv
dv/tb_vec_decode.sv

// ==== Bender.yml ====
package:
  name: vec_decode

sources:
  - files:
      - hw/vdec_isa_pkg.sv
      - hw/vdec_ctrl_pkg.sv
      - hw/vdec_op_if.sv
      - hw/vdec_opi_decode.sv
      - hw/vdec_opm_decode.sv
      - hw/vdec_unit_cfg.sv
      - hw/vdec_ctrl_gen.sv
      - hw/vec_decode_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_vec_decode_assert.sv
      - dv/tb_vec_decode.sv
